// File: common/uio_pkg.sv
package uio_pkg;

	// ***********************************************************************
	// widths shared by the upload port
	// ***********************************************************************

	// one spi transfer unit
	localparam int BYTE_W = 8;

	// floppy status word, sent and received msb first
	localparam int STATUS_W = 32;

	// external ram word and its byte lanes
	localparam int MEM_DATA_W = 32;
	localparam int MEM_SEL_W = 4;

	// ***********************************************************************
	// command opcodes sent by the io controller
	// ***********************************************************************

	typedef enum logic [BYTE_W-1:0] {
		// start or end of a file download, bit 0 of next byte
		FILE_TX = 8'h53,
		// file payload, one ram write per byte
		FILE_TX_DAT = 8'h54,
		// core status is shifted back on sdo
		FDC_GET_STATUS = 8'h55,
		// bytes handed to the floppy controller
		FDC_TX_DATA = 8'h56,
		// status word loaded msb first
		FDC_SET_STATUS = 8'h57
	} uio_cmd_e;

	// position of a byte inside one transfer
	typedef enum logic {
		PH_CMD = 1'b0,
		PH_DATA = 1'b1
	} spi_phase_e;

endpackage

// File: spi/spi_client.sv
`timescale 1ns/100ps

module spi_client (
	input logic clk,
	input logic ss,
	input logic spi_sck,
	input logic spi_cs,
	input logic spi_sdi,
	output logic spi_sdo,
	input logic [uio_pkg::BYTE_W-1:0] tx_byte,
	output logic rx_valid,
	output logic xfer_start,
	output logic [uio_pkg::BYTE_W-1:0] rx_byte,
	output uio_pkg::spi_phase_e rx_phase
);
	import uio_pkg::*;

	// two flop synchronizers, msb is the usable value
	logic [1:0] sck_sync;
	logic [1:0] cs_sync;
	logic [1:0] sdi_sync;
	logic sck_s;
	logic cs_s;
	logic sdi_s;

	// previous synchronized values for edge detection
	logic sck_prev;
	logic cs_prev;
	logic sck_rise;
	logic sck_fall;

	logic [2:0] bit_cnt;
	logic first_byte;

	// last bit is not shifted, it goes straight into rx_byte
	logic [BYTE_W-2:0] rx_sreg;
	logic [BYTE_W-1:0] tx_sreg;

	assign sck_s = sck_sync[1];
	assign cs_s = cs_sync[1];
	assign sdi_s = sdi_sync[1];

	assign sck_rise = sck_s & ~sck_prev;
	assign sck_fall = ~sck_s & sck_prev;

	// ***********************************************************************
	// pin synchronizer
	// ***********************************************************************

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			sck_sync <= '0;
			// select idles high
			cs_sync <= '1;
			sdi_sync <= '0;
			sck_prev <= 1'b0;
			cs_prev <= 1'b1;
		end else begin
			sck_sync <= {sck_sync[0], spi_sck};
			cs_sync <= {cs_sync[0], spi_cs};
			sdi_sync <= {sdi_sync[0], spi_sdi};
			sck_prev <= sck_s;
			cs_prev <= cs_s;
		end
	end

	// ***********************************************************************
	// bit counter and byte framing
	// ***********************************************************************

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			bit_cnt <= '0;
			first_byte <= 1'b1;
			rx_valid <= 1'b0;
			rx_phase <= PH_CMD;
			xfer_start <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			// falling select opens a transfer
			xfer_start <= cs_prev & ~cs_s;
			if (cs_s) begin
				// deselected, next byte is a command again
				bit_cnt <= '0;
				first_byte <= 1'b1;
			end else if (sck_rise) begin
				// wraps 7 -> 0 at the end of every byte
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					rx_valid <= 1'b1;
					rx_phase <= first_byte ? PH_CMD : PH_DATA;
					first_byte <= 1'b0;
				end
			end
		end
	end

	// input shifter, msb first
	always_ff @(posedge clk) begin
		if (!cs_s && sck_rise) begin
			rx_sreg <= {rx_sreg[BYTE_W-3:0], sdi_s};
			if (bit_cnt == 3'd7)
				rx_byte <= {rx_sreg, sdi_s};
		end
	end

	// ***********************************************************************
	// reply shifter
	// ***********************************************************************

	// the fall after bit 7 starts the next byte, so tx_byte is loaded there
	always_ff @(posedge clk or posedge ss) begin
		if (ss)
			spi_sdo <= 1'b0;
		else if (cs_s)
			spi_sdo <= 1'b0;
		else if (sck_fall)
			spi_sdo <= (bit_cnt == 3'd0) ? tx_byte[BYTE_W-1] : tx_sreg[BYTE_W-1];
	end

	always_ff @(posedge clk) begin
		if (!cs_s && sck_fall) begin
			if (bit_cnt == 3'd0)
				tx_sreg <= {tx_byte[BYTE_W-2:0], 1'b0};
			else
				tx_sreg <= {tx_sreg[BYTE_W-2:0], 1'b0};
		end
	end

	// a byte only completes while the select pin was low three clocks earlier
	a_rx_in_xfer: assert property (@(posedge clk) disable iff (ss)
		rx_valid |-> !$past(spi_cs, 3));

endmodule

// File: hdl/uio_decoder.sv
`timescale 1ns/100ps

module uio_decoder #(
	parameter int ADDR_WIDTH = 24,
	parameter int START_ADDR = 0,
	parameter int WR_DEPTH = 4
) (
	input logic clk,
	input logic ss,
	input logic rx_valid,
	input logic xfer_start,
	input logic [uio_pkg::BYTE_W-1:0] rx_byte,
	input uio_pkg::spi_phase_e rx_phase,
	output logic [uio_pkg::BYTE_W-1:0] tx_byte,
	input logic [uio_pkg::STATUS_W-1:0] fdc_status_out,
	output logic [uio_pkg::STATUS_W-1:0] fdc_status_in,
	output logic [uio_pkg::BYTE_W-1:0] fdc_data_in,
	output logic fdc_data_in_strobe,
	output logic wq_push,
	output logic [ADDR_WIDTH-1:0] wq_addr,
	output logic [uio_pkg::BYTE_W-1:0] wq_byte,
	input logic credit_return,
	output logic downloading,
	output logic overflow,
	output logic [ADDR_WIDTH-1:0] size
);
	import uio_pkg::*;

	// enough bits to hold WR_DEPTH itself
	localparam int CREDIT_W = $clog2(WR_DEPTH + 1);

	uio_cmd_e cmd;
	// data byte index that sticks at 7
	logic [2:0] byte_cnt;
	logic [ADDR_WIDTH-1:0] addr;
	logic [CREDIT_W-1:0] credit;

	logic data_byte;
	logic file_dat;
	logic accept;
	logic fdc_dat;

	assign data_byte = rx_valid && (rx_phase == PH_DATA);
	assign file_dat = data_byte && (cmd == FILE_TX_DAT);
	// spi cannot wait so a byte without credit is lost
	assign accept = file_dat && (credit != '0);
	assign fdc_dat = data_byte && (cmd == FDC_TX_DATA);

	assign size = addr - ADDR_WIDTH'(START_ADDR);

	// status byte for the next data slot with byte 0 carrying bits 31:24
	always_comb begin
		tx_byte = '0;
		if (cmd == FDC_GET_STATUS)
			tx_byte = fdc_status_out[{~byte_cnt[1:0], 3'b000} +: BYTE_W];
	end

	// ***********************************************************************
	// command decode and control state
	// ***********************************************************************

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			cmd <= FILE_TX;
			byte_cnt <= '0;
			addr <= ADDR_WIDTH'(START_ADDR);
			credit <= CREDIT_W'(WR_DEPTH);
			downloading <= 1'b0;
			overflow <= 1'b0;
			fdc_data_in_strobe <= 1'b0;
			wq_push <= 1'b0;
			fdc_status_in <= '0;
		end else begin
			wq_push <= accept;
			fdc_data_in_strobe <= fdc_dat;
			// credit leaves with the push and comes back when ram takes the entry
			credit <= credit + CREDIT_W'(credit_return) - CREDIT_W'(wq_push);
			// every transfer counts its data bytes from zero
			if (xfer_start)
				byte_cnt <= '0;
			if (rx_valid) begin
				if (rx_phase == PH_CMD) begin
					cmd <= uio_cmd_e'(rx_byte);
				end else begin
					if (byte_cnt != 3'd7)
						byte_cnt <= byte_cnt + 3'd1;
					case (cmd)
						FILE_TX: begin
							if (rx_byte[0]) begin
								// new download rewinds and clears the old overflow
								addr <= ADDR_WIDTH'(START_ADDR);
								downloading <= 1'b1;
								overflow <= 1'b0;
							end else begin
								downloading <= 1'b0;
							end
						end
						FILE_TX_DAT: begin
							if (accept)
								addr <= addr + ADDR_WIDTH'(1);
							else
								overflow <= 1'b1;
						end
						FDC_SET_STATUS: begin
							if (byte_cnt < 3'd4)
								fdc_status_in[{~byte_cnt[1:0], 3'b000} +: BYTE_W] <= rx_byte;
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	// payload toward the write queue and the floppy side
	always_ff @(posedge clk) begin
		if (accept) begin
			wq_addr <= addr;
			wq_byte <= rx_byte;
		end
		if (fdc_dat)
			fdc_data_in <= rx_byte;
	end

	// returns never outnumber the pushes that took credit
	a_credit_max: assert property (@(posedge clk) disable iff (ss)
		credit <= CREDIT_W'(WR_DEPTH));

	a_push_credit: assert property (@(posedge clk) disable iff (ss)
		wq_push |-> credit != '0);

endmodule

// File: hdl/ram_writer.sv
`timescale 1ns/100ps

module ram_writer #(
	parameter int ADDR_WIDTH = 24,
	parameter int WR_DEPTH = 4
) (
	input logic clk,
	input logic ss,
	input logic wq_push,
	input logic [ADDR_WIDTH-1:0] wq_addr,
	input logic [uio_pkg::BYTE_W-1:0] wq_byte,
	output logic credit_return,
	output logic mem_wr,
	input logic mem_ready,
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output logic [uio_pkg::MEM_SEL_W-1:0] mem_sel,
	output logic [uio_pkg::MEM_DATA_W-1:0] mem_data
);
	import uio_pkg::*;

	localparam int PTR_W = (WR_DEPTH > 1) ? $clog2(WR_DEPTH) : 1;
	localparam int CNT_W = $clog2(WR_DEPTH + 1);

	// busy while the queue holds a head entry
	typedef enum logic {
		WR_IDLE,
		WR_BUSY
	} wr_state_e;

	wr_state_e state;

	// queue storage
	logic [ADDR_WIDTH-1:0] addr_q [WR_DEPTH];
	logic [BYTE_W-1:0] byte_q [WR_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [BYTE_W-1:0] head_byte;

	// circular increment, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(WR_DEPTH - 1)) ? '0 : p + PTR_W'(1);
	endfunction

	always_ff @(posedge clk) begin
		if (wq_push) begin
			addr_q[wr_ptr] <= wq_addr;
			byte_q[wr_ptr] <= wq_byte;
		end
	end

	// ***********************************************************************
	// queue pointers and handshake state
	// ***********************************************************************

	always_ff @(posedge clk or posedge ss) begin
		if (ss) begin
			state <= WR_IDLE;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wq_push)
				wr_ptr <= ptr_next(wr_ptr);
			// head leaves on the accepted write
			if (credit_return)
				rd_ptr <= ptr_next(rd_ptr);
			count <= count + CNT_W'(wq_push) - CNT_W'(credit_return);
			case (state)
				WR_IDLE: begin
					if (wq_push)
						state <= WR_BUSY;
				end
				WR_BUSY: begin
					// last entry gone and nothing new behind it
					if (credit_return && (count == CNT_W'(1)) && !wq_push)
						state <= WR_IDLE;
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	assign mem_wr = (state == WR_BUSY);
	assign credit_return = mem_wr & mem_ready;

	// head entry is presented straight from the queue
	assign mem_addr = addr_q[rd_ptr];
	assign head_byte = byte_q[rd_ptr];
	// one hot lane from the low address bits
	assign mem_sel = MEM_SEL_W'(1) << mem_addr[1:0];
	// byte copied onto every lane, sel picks the one that is written
	assign mem_data = {MEM_SEL_W{head_byte}};

	// decoder credit keeps the queue from overfilling
	a_no_full_push: assert property (@(posedge clk) disable iff (ss)
		wq_push |-> count < CNT_W'(WR_DEPTH));

	a_hold_stable: assert property (@(posedge clk) disable iff (ss)
		mem_wr && !mem_ready |=> mem_wr && $stable(mem_addr) && $stable(mem_sel)
			&& $stable(mem_data));

endmodule

// File: hdl/data_io_top.sv
`timescale 1ns/100ps

module data_io_top #(
	parameter int ADDR_WIDTH = 24,
	parameter int START_ADDR = 0,
	parameter int WR_DEPTH = 4
) (
	input logic clk,
	input logic ss,
	// io controller spi
	input logic spi_sck,
	input logic spi_cs,
	input logic spi_sdi,
	output logic spi_sdo,
	// download status
	output logic downloading,
	output logic [ADDR_WIDTH-1:0] size,
	output logic overflow,
	// floppy emulation
	input logic [uio_pkg::STATUS_W-1:0] fdc_status_out,
	output logic [uio_pkg::STATUS_W-1:0] fdc_status_in,
	output logic [uio_pkg::BYTE_W-1:0] fdc_data_in,
	output logic fdc_data_in_strobe,
	// external ram
	output logic mem_wr,
	input logic mem_ready,
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output logic [uio_pkg::MEM_SEL_W-1:0] mem_sel,
	output logic [uio_pkg::MEM_DATA_W-1:0] mem_data
);
	import uio_pkg::*;

	// client to decoder
	logic rx_valid;
	logic xfer_start;
	logic [BYTE_W-1:0] rx_byte;
	spi_phase_e rx_phase;
	logic [BYTE_W-1:0] tx_byte;

	// decoder to writer, credit based
	logic wq_push;
	logic [ADDR_WIDTH-1:0] wq_addr;
	logic [BYTE_W-1:0] wq_byte;
	logic credit_return;

	spi_client i_spi_client (
		.clk(clk),
		.ss(ss),
		.spi_sck(spi_sck),
		.spi_cs(spi_cs),
		.spi_sdi(spi_sdi),
		.spi_sdo(spi_sdo),
		.tx_byte(tx_byte),
		.rx_valid(rx_valid),
		.xfer_start(xfer_start),
		.rx_byte(rx_byte),
		.rx_phase(rx_phase)
	);

	uio_decoder #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.START_ADDR(START_ADDR),
		.WR_DEPTH(WR_DEPTH)
	) i_uio_decoder (
		.clk(clk),
		.ss(ss),
		.rx_valid(rx_valid),
		.xfer_start(xfer_start),
		.rx_byte(rx_byte),
		.rx_phase(rx_phase),
		.tx_byte(tx_byte),
		.fdc_status_out(fdc_status_out),
		.fdc_status_in(fdc_status_in),
		.fdc_data_in(fdc_data_in),
		.fdc_data_in_strobe(fdc_data_in_strobe),
		.wq_push(wq_push),
		.wq_addr(wq_addr),
		.wq_byte(wq_byte),
		.credit_return(credit_return),
		.downloading(downloading),
		.overflow(overflow),
		.size(size)
	);

	ram_writer #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.WR_DEPTH(WR_DEPTH)
	) i_ram_writer (
		.clk(clk),
		.ss(ss),
		.wq_push(wq_push),
		.wq_addr(wq_addr),
		.wq_byte(wq_byte),
		.credit_return(credit_return),
		.mem_wr(mem_wr),
		.mem_ready(mem_ready),
		.mem_addr(mem_addr),
		.mem_sel(mem_sel),
		.mem_data(mem_data)
	);

endmodule

// File: bench/data_io_tb.sv
`timescale 1ns/100ps

module data_io_tb;
	import uio_pkg::*;

	localparam int ADDR_WIDTH = 24;
	// unaligned start address so the lane select walks through all four lanes
	localparam int START_ADDR = 'h1002;
	localparam int WR_DEPTH = 4;
	// clk cycles per spi_sck phase
	localparam int HALF_CLKS = 4;
	// 17 download, 17 stalls, 15 overflow, 5 set, 5 get and 6 floppy bytes
	localparam int XFER_BYTES = 17 + 17 + 15 + 5 + 5 + 6;
	// every spi bit takes 8 clocks with slack added for gaps and ram drain
	localparam int TIMEOUT_CYCLES = XFER_BYTES * 8 * 8 + 2000;

	// ram model behavior
	localparam int RAM_READY = 0;
	localparam int RAM_RANDOM = 1;
	localparam int RAM_HOLD = 2;

	logic clk;
	logic ss;
	logic spi_sck;
	logic spi_cs;
	logic spi_sdi;
	logic spi_sdo;
	logic downloading;
	logic [ADDR_WIDTH-1:0] size;
	logic overflow;
	logic [STATUS_W-1:0] fdc_status_out;
	logic [STATUS_W-1:0] fdc_status_in;
	logic [BYTE_W-1:0] fdc_data_in;
	logic fdc_data_in_strobe;
	logic mem_wr;
	logic mem_ready;
	logic [ADDR_WIDTH-1:0] mem_addr;
	logic [MEM_SEL_W-1:0] mem_sel;
	logic [MEM_DATA_W-1:0] mem_data;

	integer seed = 32'had505f8a;
	int ram_mode = RAM_READY;
	int value_errors = 0;
	int other_errors = 0;
	int write_count = 0;
	int cycles = 0;
	string test_name = "reset";

	// payload of the next transfer and the reply bytes seen during it
	logic [BYTE_W-1:0] xfer_tx[$];
	logic [BYTE_W-1:0] xfer_rx[$];
	// writes the ram should see with the oldest first
	logic [ADDR_WIDTH-1:0] exp_addr_q[$];
	logic [BYTE_W-1:0] exp_byte_q[$];
	logic [ADDR_WIDTH-1:0] exp_a;
	logic [BYTE_W-1:0] exp_b;
	// bytes captured on floppy strobes
	logic [BYTE_W-1:0] strobe_q[$];

	data_io_top #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.START_ADDR(START_ADDR),
		.WR_DEPTH(WR_DEPTH)
	) i_dut (
		.clk(clk),
		.ss(ss),
		.spi_sck(spi_sck),
		.spi_cs(spi_cs),
		.spi_sdi(spi_sdi),
		.spi_sdo(spi_sdo),
		.downloading(downloading),
		.size(size),
		.overflow(overflow),
		.fdc_status_out(fdc_status_out),
		.fdc_status_in(fdc_status_in),
		.fdc_data_in(fdc_data_in),
		.fdc_data_in_strobe(fdc_data_in_strobe),
		.mem_wr(mem_wr),
		.mem_ready(mem_ready),
		.mem_addr(mem_addr),
		.mem_sel(mem_sel),
		.mem_data(mem_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ************************************************************************
	// reference model
	// ************************************************************************

	// one lane per low address pair
	function automatic logic [MEM_SEL_W-1:0] lane_select(input logic [ADDR_WIDTH-1:0] a);
		lane_select = '0;
		lane_select[a[1:0]] = 1'b1;
	endfunction

	function automatic logic [MEM_DATA_W-1:0] replicate_byte(input logic [BYTE_W-1:0] b);
		return {b, b, b, b};
	endfunction

	// first byte on the wire is the most significant
	function automatic logic [STATUS_W-1:0] pack_status(input logic [BYTE_W-1:0] b0,
		input logic [BYTE_W-1:0] b1, input logic [BYTE_W-1:0] b2,
		input logic [BYTE_W-1:0] b3);
		return {b0, b1, b2, b3};
	endfunction

	task automatic compare_word(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp === act) else begin
			$display("error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
			value_errors++;
		end
	endtask

	task automatic finish_run();
		$display("error count: %0d wrong values, %0d other errors", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	// ************************************************************************
	// ram model, monitors and timeout
	// ************************************************************************

	// ready is low 60% of the time in random mode
	initial begin
		mem_ready = 1'b1;
		forever begin
			@(posedge clk);
			if (ram_mode == RAM_HOLD)
				mem_ready <= 1'b0;
			else if (ram_mode == RAM_RANDOM)
				mem_ready <= ($unsigned($random(seed)) % 100) >= 60;
			else
				mem_ready <= 1'b1;
		end
	end

	// accepted writes against the expected order
	always @(posedge clk) begin
		if (!ss && mem_wr && mem_ready) begin
			write_count++;
			if (exp_addr_q.size() == 0) begin
				$display("unexpected ram write at address %h in %s", mem_addr, test_name);
				other_errors++;
			end else begin
				exp_a = exp_addr_q.pop_front();
				exp_b = exp_byte_q.pop_front();
				compare_word("ram address", 32'(exp_a), 32'(mem_addr));
				compare_word("ram select", 32'(lane_select(exp_a)), 32'(mem_sel));
				compare_word("ram data", replicate_byte(exp_b), mem_data);
			end
		end
	end

	always @(posedge clk) begin
		if (!ss && fdc_data_in_strobe)
			strobe_q.push_back(fdc_data_in);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not end within %0d clock cycles", cycles);
			other_errors++;
			finish_run();
		end
	end

	// ************************************************************************
	// spi master
	// ************************************************************************

	// mode 0 with msb first and the reply bit sampled just before the rising edge
	task automatic shift_byte(input logic [BYTE_W-1:0] mosi,
		output logic [BYTE_W-1:0] miso);
		int i;
		for (i = BYTE_W - 1; i >= 0; i--) begin
			spi_sdi <= mosi[i];
			repeat (HALF_CLKS) @(posedge clk);
			miso[i] = spi_sdo;
			spi_sck <= 1'b1;
			repeat (HALF_CLKS) @(posedge clk);
			spi_sck <= 1'b0;
		end
	endtask

	// command byte then xfer_tx with the replies of the data bytes landing in xfer_rx
	task automatic run_transfer(input logic [BYTE_W-1:0] cmd);
		logic [BYTE_W-1:0] rx;
		int i;
		xfer_rx.delete();
		spi_cs <= 1'b0;
		repeat (HALF_CLKS) @(posedge clk);
		shift_byte(cmd, rx);
		for (i = 0; i < xfer_tx.size(); i++) begin
			shift_byte(xfer_tx[i], rx);
			xfer_rx.push_back(rx);
		end
		repeat (HALF_CLKS) @(posedge clk);
		spi_cs <= 1'b1;
		repeat (2 * HALF_CLKS) @(posedge clk);
	endtask

	task automatic send_file_flag(input logic [BYTE_W-1:0] flag);
		xfer_tx.delete();
		xfer_tx.push_back(flag);
		run_transfer(FILE_TX);
	endtask

	task automatic wait_drain();
		while (exp_addr_q.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk);
	endtask

	// ************************************************************************
	// tests
	// ************************************************************************

	task automatic download_file(input int count);
		logic [BYTE_W-1:0] b;
		int i;
		int base;
		send_file_flag(8'h01);
		compare_word("downloading after start", 32'd1, 32'(downloading));
		xfer_tx.delete();
		for (i = 0; i < count; i++) begin
			b = 8'($random(seed));
			xfer_tx.push_back(b);
			exp_addr_q.push_back(ADDR_WIDTH'(START_ADDR + i));
			exp_byte_q.push_back(b);
		end
		base = write_count;
		run_transfer(FILE_TX_DAT);
		wait_drain();
		send_file_flag(8'h00);
		compare_word("downloading after end", 32'd0, 32'(downloading));
		compare_word("written bytes", 32'(count), 32'(write_count - base));
		compare_word("size", 32'(count), 32'(size));
		compare_word("overflow", 32'd0, 32'(overflow));
	endtask

	// ram stalls for the whole payload so only the credited bytes get through
	task automatic fill_without_credit(input int count);
		logic [BYTE_W-1:0] b;
		int i;
		int base;
		send_file_flag(8'h01);
		ram_mode = RAM_HOLD;
		xfer_tx.delete();
		for (i = 0; i < count; i++) begin
			b = 8'($random(seed));
			xfer_tx.push_back(b);
			if (i < WR_DEPTH) begin
				exp_addr_q.push_back(ADDR_WIDTH'(START_ADDR + i));
				exp_byte_q.push_back(b);
			end
		end
		base = write_count;
		run_transfer(FILE_TX_DAT);
		ram_mode = RAM_READY;
		wait_drain();
		compare_word("written bytes", 32'(WR_DEPTH), 32'(write_count - base));
		compare_word("overflow", 32'd1, 32'(overflow));
		compare_word("size", 32'(WR_DEPTH), 32'(size));
		send_file_flag(8'h00);
	endtask

	task automatic load_status();
		int i;
		xfer_tx.delete();
		for (i = 0; i < 4; i++)
			xfer_tx.push_back(8'($random(seed)));
		run_transfer(FDC_SET_STATUS);
		compare_word("status in", pack_status(xfer_tx[0], xfer_tx[1], xfer_tx[2],
			xfer_tx[3]), fdc_status_in);
	endtask

	task automatic read_status();
		int i;
		fdc_status_out <= 32'($random(seed));
		xfer_tx.delete();
		for (i = 0; i < 4; i++)
			xfer_tx.push_back(8'($random(seed)));
		run_transfer(FDC_GET_STATUS);
		compare_word("status on sdo", fdc_status_out, pack_status(xfer_rx[0], xfer_rx[1],
			xfer_rx[2], xfer_rx[3]));
	endtask

	task automatic send_floppy_bytes(input int count);
		int i;
		int base;
		base = strobe_q.size();
		xfer_tx.delete();
		for (i = 0; i < count; i++)
			xfer_tx.push_back(8'($random(seed)));
		run_transfer(FDC_TX_DATA);
		// no strobe may come from earlier commands either
		compare_word("strobe count", 32'(count), 32'(strobe_q.size()));
		if (strobe_q.size() - base == count) begin
			for (i = 0; i < count; i++)
				compare_word("floppy byte", 32'(xfer_tx[i]), 32'(strobe_q[base + i]));
		end
	endtask

	initial begin
		ss = 1'b1;
		spi_sck = 1'b0;
		spi_cs = 1'b1;
		spi_sdi = 1'b0;
		fdc_status_out = '0;
		repeat (2) @(posedge clk);
		ss <= 1'b0;
		repeat (2) @(posedge clk);
		test_name = "download";
		download_file(12);
		test_name = "stalls";
		ram_mode = RAM_RANDOM;
		download_file(12);
		ram_mode = RAM_READY;
		test_name = "overflow";
		fill_without_credit(10);
		test_name = "set status";
		load_status();
		test_name = "get status";
		read_status();
		test_name = "floppy data";
		send_floppy_bytes(5);
		finish_run();
	end

endmodule

// File: src.f
common/uio_pkg.sv
spi/spi_client.sv
hdl/uio_decoder.sv
hdl/ram_writer.sv
hdl/data_io_top.sv
bench/data_io_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP ?= data_io_tb
RTL_TOP ?= data_io_top
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
PASS_MSG = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
